// ==== Bender.yml ====
package:
  name: uart_wb_bridge

sources:
  - rtl/uart_wb_pkg.sv
  - rtl/uart_rx.sv
  - rtl/cmd_decoder.sv
  - rtl/wb_master.sv
  - rtl/wb_led_slave.sv
  - rtl/rsp_encoder.sv
  - rtl/uart_tx.sv
  - rtl/uart_wb_bridge.sv
  - target: simulation
    files:
      - dv/tb_uart_wb_bridge.sv

// ==== dv/tb_uart_wb_bridge.sv ====
`timescale 1ns/10ps

module tb_uart_wb_bridge;

    localparam int CLKS_PER_BIT = 8;
    localparam int N_LED = 6;
    localparam int N_SCR = 20;
    localparam int N_BAD = 4;
    localparam int N_STRAY = 3;
    localparam int N_JUNK = 3;
    localparam int QUIET_CYCLES = 2 * 10 * CLKS_PER_BIT;
    // Bytes on the line per test, the quiet window counted as two bytes
    localparam int TOTAL_BYTES = 12 + (6 + 12 * N_LED) + (6 + 12 * N_SCR) + 24
                               + 14 * N_BAD + N_STRAY * (N_JUNK + 2 + 12);
    localparam int LIMIT = TOTAL_BYTES * 10 * CLKS_PER_BIT * 2 + 20;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               uart_rx;
    logic               uart_tx;
    uart_wb_pkg::byte_t leds;

    logic [31:0]           lfsr = 32'hcc87_fadb;
    int                    cycles = 0;
    string                 cur_test;
    int                    test_errs;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    // Model starts from the reset state
    uart_wb_pkg::wb_addr_t m_addr = '0;
    uart_wb_pkg::byte_t    m_leds = '0;
    uart_wb_pkg::word_t    m_scratch;
    uart_wb_pkg::word_t    m_id = 32'h5542_0001;

    uart_wb_bridge #(.CLKS_PER_BIT(CLKS_PER_BIT)) DUT (
        .i_clk_12Mhz (clk),
        .i_rst_n     (rst_n),
        .i_uart_rx   (uart_rx),
        .o_uart_tx   (uart_tx),
        .o_leds      (leds)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic get_rand(input int nbits, output uart_wb_pkg::word_t val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs == 0) begin
            $display("PASS %s", cur_test);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic report_mismatch(input string what, input uart_wb_pkg::word_t exp,
                                   input uart_wb_pkg::word_t act);
        $display("ERROR %s: %s expected 0x%08h, got 0x%08h", cur_test, what, exp, act);
        test_errs++;
    endtask

    task automatic report_fail(input string msg);
        $display("Failure in %s: %s", cur_test, msg);
        test_errs++;
    endtask

    task automatic send_byte(input uart_wb_pkg::byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    // Samples at bit midpoints, on falling edges
    task automatic recv_byte(output uart_wb_pkg::byte_t b);
        b = '0;
        @(negedge clk);
        while (uart_tx !== 1'b0) @(negedge clk);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        if (uart_tx !== 1'b0) report_fail("start bit on o_uart_tx not low at its middle");
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        if (uart_tx !== 1'b1) report_fail("stop bit on o_uart_tx is low");
    endtask

    // Register model of the bridge and its peripheral
    task automatic predict(input uart_wb_pkg::byte_t op, input uart_wb_pkg::word_t data,
                           output uart_wb_pkg::rsp_code_t code,
                           output uart_wb_pkg::word_t rdata);
        code  = uart_wb_pkg::RSP_BUS_ERR;
        rdata = '0;
        if (op == uart_wb_pkg::OP_SET_ADDR) begin
            m_addr = data[29:0];
            code   = uart_wb_pkg::RSP_ADDR_OK;
        end else if (op == uart_wb_pkg::OP_WRITE) begin
            if (m_addr == uart_wb_pkg::ADDR_LEDS) begin
                m_leds = data[7:0];
                code   = uart_wb_pkg::RSP_WRITE_OK;
            end else if (m_addr == uart_wb_pkg::ADDR_SCRATCH) begin
                m_scratch = data;
                code      = uart_wb_pkg::RSP_WRITE_OK;
            end
        end else if (op == uart_wb_pkg::OP_READ) begin
            if (m_addr <= uart_wb_pkg::ADDR_ID) begin
                code = uart_wb_pkg::RSP_READ_DATA;
            end
            if (m_addr == uart_wb_pkg::ADDR_LEDS) rdata = {24'h0, m_leds};
            if (m_addr == uart_wb_pkg::ADDR_SCRATCH) rdata = m_scratch;
            if (m_addr == uart_wb_pkg::ADDR_ID) rdata = m_id;
        end
    endtask

    // Sends one command and collects the whole response
    task automatic issue_cmd(input uart_wb_pkg::byte_t op, input uart_wb_pkg::word_t data);
        uart_wb_pkg::rsp_code_t exp_code;
        uart_wb_pkg::word_t     exp_data;
        uart_wb_pkg::byte_t     got_code;
        uart_wb_pkg::byte_t     b;
        uart_wb_pkg::word_t     got_data;
        int                     nsend;
        nsend = (op == uart_wb_pkg::OP_READ) ? 1 : 5;
        got_data = '0;
        predict(op, data, exp_code, exp_data);
        fork
            begin
                send_byte(op);
                for (int i = 0; i < nsend - 1; i++) send_byte(data[31 - 8 * i -: 8]);
            end
            begin
                recv_byte(got_code);
                if (got_code == uart_wb_pkg::RSP_READ_DATA) begin
                    for (int j = 0; j < 4; j++) begin
                        recv_byte(b);
                        got_data = {got_data[23:0], b};
                    end
                end
            end
        join
        if (got_code !== exp_code) begin
            report_mismatch("response code", exp_code, got_code);
        end else if (exp_code == uart_wb_pkg::RSP_READ_DATA && got_data !== exp_data) begin
            report_mismatch("read data", exp_data, got_data);
        end
    endtask

    initial begin
        uart_wb_pkg::word_t val;
        logic               seen;
        rst_n   = 1'b0;
        uart_rx = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        start_test("reset");
        if (uart_tx !== 1'b1) report_fail("o_uart_tx is not high after reset");
        if (leds !== 8'h00) report_mismatch("o_leds", 32'h0, leds);
        issue_cmd(uart_wb_pkg::OP_SET_ADDR, uart_wb_pkg::ADDR_LEDS);
        issue_cmd(uart_wb_pkg::OP_READ, '0);
        end_test();

        start_test("led_write");
        issue_cmd(uart_wb_pkg::OP_SET_ADDR, uart_wb_pkg::ADDR_LEDS);
        for (int i = 0; i < N_LED; i++) begin
            get_rand(32, val);
            issue_cmd(uart_wb_pkg::OP_WRITE, val);
            if (leds !== val[7:0]) report_mismatch("o_leds", val[7:0], leds);
            issue_cmd(uart_wb_pkg::OP_READ, '0);
        end
        end_test();

        start_test("scratch");
        issue_cmd(uart_wb_pkg::OP_SET_ADDR, uart_wb_pkg::ADDR_SCRATCH);
        for (int i = 0; i < N_SCR; i++) begin
            get_rand(32, val);
            issue_cmd(uart_wb_pkg::OP_WRITE, val);
            issue_cmd(uart_wb_pkg::OP_READ, '0);
        end
        end_test();

        start_test("id_reg");
        issue_cmd(uart_wb_pkg::OP_SET_ADDR, uart_wb_pkg::ADDR_ID);
        issue_cmd(uart_wb_pkg::OP_READ, '0);
        get_rand(32, val);
        issue_cmd(uart_wb_pkg::OP_WRITE, val);
        issue_cmd(uart_wb_pkg::OP_READ, '0);
        end_test();

        start_test("bus_error");
        for (int i = 0; i < N_BAD; i++) begin
            get_rand(32, val);
            // Bit 29 set keeps the word address above the register map
            val[29] = 1'b1;
            issue_cmd(uart_wb_pkg::OP_SET_ADDR, val);
            issue_cmd(uart_wb_pkg::OP_READ, '0);
            get_rand(32, val);
            issue_cmd(uart_wb_pkg::OP_WRITE, val);
            if (leds !== m_leds) report_mismatch("o_leds", m_leds, leds);
        end
        end_test();

        start_test("stray_bytes");
        for (int k = 0; k < N_STRAY; k++) begin
            for (int j = 0; j < N_JUNK; j++) begin
                get_rand(8, val);
                if (val[7:0] >= 8'h01 && val[7:0] <= 8'h03) val[7] = 1'b1;
                send_byte(val[7:0]);
            end
            seen = 1'b0;
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                if (uart_tx !== 1'b1) seen = 1'b1;
            end
            if (seen) report_fail("o_uart_tx was active after unknown opcode bytes");
            issue_cmd(uart_wb_pkg::OP_SET_ADDR, k);
            issue_cmd(uart_wb_pkg::OP_READ, '0);
        end
        end_test();

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== rtl/cmd_decoder.sv ====
`timescale 1ns/10ps

module cmd_decoder (
    input  logic               i_clk_12Mhz,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  uart_wb_pkg::byte_t i_byte,
    input  logic               i_ready,
    output logic               o_valid,
    output uart_wb_pkg::cmd_t  o_cmd
);

    typedef enum logic [1:0] {D_OPCODE, D_PAYLOAD, D_HOLD} dec_state_t;

    dec_state_t        state;
    uart_wb_pkg::cmd_t cmd_q;
    logic [1:0]        byte_cnt;

    assign o_valid = (state == D_HOLD);
    assign o_cmd   = cmd_q;

    always_ff @(posedge i_clk_12Mhz) begin
        if (!i_rst_n) begin
            state    <= D_OPCODE;
            byte_cnt <= '0;
        end else begin
            case (state)
                D_OPCODE: begin
                    if (i_valid) begin
                        cmd_q.op   <= i_byte;
                        cmd_q.data <= '0;
                        byte_cnt   <= '0;
                        case (i_byte)
                            uart_wb_pkg::OP_SET_ADDR,
                            uart_wb_pkg::OP_WRITE:    state <= D_PAYLOAD;
                            uart_wb_pkg::OP_READ:     state <= D_HOLD;
                            // Unknown opcode, stay and wait for the next byte
                            default:                  state <= D_OPCODE;
                        endcase
                    end
                end
                D_PAYLOAD: begin
                    if (i_valid) begin
                        // MSB arrives first
                        cmd_q.data <= {cmd_q.data[23:0], i_byte};
                        byte_cnt   <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'd3) begin
                            state <= D_HOLD;
                        end
                    end
                end
                D_HOLD: begin
                    if (i_ready) begin
                        state <= D_OPCODE;
                    end
                end
                default: state <= D_OPCODE;
            endcase
        end
    end

    a_cmd_stable: assert property (@(posedge i_clk_12Mhz) disable iff (!i_rst_n)
        o_valid && !i_ready |=> o_valid && $stable(o_cmd));

endmodule

// ==== rtl/rsp_encoder.sv ====
`timescale 1ns/10ps

module rsp_encoder (
    input  logic               i_clk_12Mhz,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  uart_wb_pkg::rsp_t  i_rsp,
    output logic               o_ready,
    output logic               o_tx_valid,
    output uart_wb_pkg::byte_t o_tx_byte,
    input  logic               i_tx_ready
);

    logic              busy_q;
    uart_wb_pkg::rsp_t shift_q;
    logic [2:0]        sent_q;
    logic [2:0]        last_q;

    assign o_ready    = !busy_q;
    assign o_tx_valid = busy_q;
    // Code byte first, then data MSB first
    assign o_tx_byte  = shift_q.code;

    always_ff @(posedge i_clk_12Mhz) begin
        if (!i_rst_n) begin
            busy_q <= 1'b0;
            sent_q <= '0;
            last_q <= '0;
        end else if (!busy_q) begin
            if (i_valid) begin
                busy_q  <= 1'b1;
                shift_q <= i_rsp;
                sent_q  <= '0;
                // Only read data carries a payload
                last_q  <= (i_rsp.code == uart_wb_pkg::RSP_READ_DATA) ? 3'd4 : 3'd0;
            end
        end else if (i_tx_ready) begin
            shift_q <= {shift_q.data, 8'h00};
            sent_q  <= sent_q + 1'b1;
            if (sent_q == last_q) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx #(
    parameter int unsigned CLKS_PER_BIT = 104
) (
    input  logic               i_clk_12Mhz,
    input  logic               i_rst_n,
    input  logic               i_uart_rx,
    output logic               o_valid,
    output uart_wb_pkg::byte_t o_byte
);

    localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] BIT_HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);

    typedef enum logic [1:0] {R_IDLE, R_START, R_DATA, R_STOP} rx_state_t;

    rx_state_t          state;
    logic               rx_meta;
    logic               rx_sync;
    logic               rx_prev;
    logic [CNT_W-1:0]   clk_cnt;
    logic [2:0]         bit_idx;
    uart_wb_pkg::byte_t shift_q;
    logic               valid_q;

    assign o_valid = valid_q;
    assign o_byte  = shift_q;

    // Line idles high
    always_ff @(posedge i_clk_12Mhz) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_uart_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge i_clk_12Mhz) begin
        if (!i_rst_n) begin
            state   <= R_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            valid_q <= 1'b0;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            valid_q <= 1'b0;
            case (state)
                R_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= R_START;
                    end
                end
                R_START: begin
                    // Glitch check at the middle of the start bit
                    if (clk_cnt == BIT_HALF) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? R_IDLE : R_DATA;
                    end
                end
                R_DATA: begin
                    if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        shift_q <= {rx_sync, shift_q[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= R_STOP;
                        end
                    end
                end
                R_STOP: begin
                    if (clk_cnt == BIT_LAST) begin
                        // Low stop bit means a framing error, drop it
                        valid_q <= rx_sync;
                        state   <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx #(
    parameter int unsigned CLKS_PER_BIT = 104
) (
    input  logic               i_clk_12Mhz,
    input  logic               i_rst_n,
    input  logic               i_valid,
    input  uart_wb_pkg::byte_t i_byte,
    output logic               o_ready,
    output logic               o_uart_tx
);

    localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {T_IDLE, T_START, T_DATA, T_STOP} tx_state_t;

    tx_state_t          state;
    logic [CNT_W-1:0]   clk_cnt;
    logic [2:0]         bit_idx;
    uart_wb_pkg::byte_t shift_q;
    logic               tx_q;
    logic               bit_end;

    assign bit_end   = (clk_cnt == BIT_LAST);
    assign o_ready   = (state == T_IDLE);
    assign o_uart_tx = tx_q;

    always_ff @(posedge i_clk_12Mhz) begin
        if (!i_rst_n) begin
            state   <= T_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx_q    <= 1'b1;
        end else begin
            clk_cnt <= (state == T_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                T_IDLE: begin
                    if (i_valid) begin
                        shift_q <= i_byte;
                        tx_q    <= 1'b0;
                        state   <= T_START;
                    end
                end
                T_START: begin
                    if (bit_end) begin
                        tx_q    <= shift_q[0];
                        bit_idx <= '0;
                        state   <= T_DATA;
                    end
                end
                T_DATA: begin
                    // LSB first
                    if (bit_end) begin
                        shift_q <= {1'b0, shift_q[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            tx_q  <= 1'b1;
                            state <= T_STOP;
                        end else begin
                            tx_q <= shift_q[1];
                        end
                    end
                end
                T_STOP: begin
                    if (bit_end) begin
                        state <= T_IDLE;
                    end
                end
                default: state <= T_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/uart_wb_bridge.sv ====
`timescale 1ns/10ps

module uart_wb_bridge #(
    parameter int unsigned CLKS_PER_BIT = 104
) (
    input  logic               i_clk_12Mhz,
    input  logic               i_rst_n,
    input  logic               i_uart_rx,
    output logic               o_uart_tx,
    output uart_wb_pkg::byte_t o_leds
);

    logic                  rx_valid;
    uart_wb_pkg::byte_t    rx_byte;
    logic                  cmd_valid;
    logic                  cmd_ready;
    uart_wb_pkg::cmd_t     cmd;
    logic                  rsp_valid;
    logic                  rsp_ready;
    uart_wb_pkg::rsp_t     rsp;
    logic                  tx_valid;
    logic                  tx_ready;
    uart_wb_pkg::byte_t    tx_byte;

    // Wishbone between master and slave
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    uart_wb_pkg::wb_addr_t wb_addr;
    uart_wb_pkg::word_t    wb_wdata;
    uart_wb_pkg::word_t    wb_rdata;
    logic                  wb_stall;
    logic                  wb_ack;
    logic                  wb_err;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_rx (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst_n     (i_rst_n),
        .i_uart_rx   (i_uart_rx),
        .o_valid     (rx_valid),
        .o_byte      (rx_byte)
    );

    cmd_decoder u_cmd_decoder (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst_n     (i_rst_n),
        .i_valid     (rx_valid),
        .i_byte      (rx_byte),
        .i_ready     (cmd_ready),
        .o_valid     (cmd_valid),
        .o_cmd       (cmd)
    );

    wb_master u_wb_master (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (cmd_valid),
        .i_cmd       (cmd),
        .o_cmd_ready (cmd_ready),
        .o_rsp_valid (rsp_valid),
        .o_rsp       (rsp),
        .i_rsp_ready (rsp_ready),
        .o_wb_cyc    (wb_cyc),
        .o_wb_stb    (wb_stb),
        .o_wb_we     (wb_we),
        .o_wb_addr   (wb_addr),
        .o_wb_data   (wb_wdata),
        .i_wb_stall  (wb_stall),
        .i_wb_ack    (wb_ack),
        .i_wb_err    (wb_err),
        .i_wb_data   (wb_rdata)
    );

    wb_led_slave u_wb_led_slave (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst_n     (i_rst_n),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_addr   (wb_addr),
        .i_wb_data   (wb_wdata),
        .o_wb_stall  (wb_stall),
        .o_wb_ack    (wb_ack),
        .o_wb_err    (wb_err),
        .o_wb_data   (wb_rdata),
        .o_leds      (o_leds)
    );

    rsp_encoder u_rsp_encoder (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst_n     (i_rst_n),
        .i_valid     (rsp_valid),
        .i_rsp       (rsp),
        .o_ready     (rsp_ready),
        .o_tx_valid  (tx_valid),
        .o_tx_byte   (tx_byte),
        .i_tx_ready  (tx_ready)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .i_clk_12Mhz (i_clk_12Mhz),
        .i_rst_n     (i_rst_n),
        .i_valid     (tx_valid),
        .i_byte      (tx_byte),
        .o_ready     (tx_ready),
        .o_uart_tx   (o_uart_tx)
    );

endmodule

// ==== rtl/uart_wb_pkg.sv ====
package uart_wb_pkg;

    // Widths with a meaning of their own
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [29:0] wb_addr_t;
    typedef logic [7:0]  opcode_t;
    typedef logic [7:0]  rsp_code_t;

    // Command opcodes, first byte from the host
    localparam opcode_t OP_SET_ADDR = 8'h01;
    localparam opcode_t OP_WRITE    = 8'h02;
    localparam opcode_t OP_READ     = 8'h03;

    // Response codes, first byte back to the host
    localparam rsp_code_t RSP_ADDR_OK   = 8'h81;
    localparam rsp_code_t RSP_WRITE_OK  = 8'h82;
    localparam rsp_code_t RSP_READ_DATA = 8'h83;
    localparam rsp_code_t RSP_BUS_ERR   = 8'h8E;

    typedef struct packed {
        opcode_t op;
        word_t   data;
    } cmd_t;

    typedef struct packed {
        rsp_code_t code;
        word_t     data;
    } rsp_t;

    // Register map, word addresses
    localparam wb_addr_t ADDR_LEDS    = 30'd0;
    localparam wb_addr_t ADDR_SCRATCH = 30'd1;
    localparam wb_addr_t ADDR_ID      = 30'd2;

    localparam word_t ID_WORD = 32'h5542_0001;

endpackage

// ==== rtl/wb_led_slave.sv ====
`timescale 1ns/10ps

module wb_led_slave (
    input  logic                  i_clk_12Mhz,
    input  logic                  i_rst_n,
    input  logic                  i_wb_cyc,
    input  logic                  i_wb_stb,
    input  logic                  i_wb_we,
    input  uart_wb_pkg::wb_addr_t i_wb_addr,
    input  uart_wb_pkg::word_t    i_wb_data,
    output logic                  o_wb_stall,
    output logic                  o_wb_ack,
    output logic                  o_wb_err,
    output uart_wb_pkg::word_t    o_wb_data,
    output uart_wb_pkg::byte_t    o_leds
);

    logic               req;
    logic               ack_q;
    logic               err_q;
    uart_wb_pkg::byte_t leds_q;
    uart_wb_pkg::word_t scratch_q;
    uart_wb_pkg::word_t rdata_q;

    assign req        = i_wb_cyc && i_wb_stb;
    assign o_wb_stall = 1'b0;
    assign o_wb_ack   = ack_q;
    assign o_wb_err   = err_q;
    assign o_wb_data  = rdata_q;
    assign o_leds     = leds_q;

    always_ff @(posedge i_clk_12Mhz) begin
        if (!i_rst_n) begin
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
            leds_q <= '0;
        end else begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            if (req) begin
                case (i_wb_addr)
                    uart_wb_pkg::ADDR_LEDS: begin
                        ack_q <= 1'b1;
                        if (i_wb_we) begin
                            leds_q <= i_wb_data[7:0];
                        end
                    end
                    uart_wb_pkg::ADDR_SCRATCH: ack_q <= 1'b1;
                    // ID is read only
                    uart_wb_pkg::ADDR_ID: begin
                        ack_q <= !i_wb_we;
                        err_q <= i_wb_we;
                    end
                    default: err_q <= 1'b1;
                endcase
            end
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge i_clk_12Mhz) begin
        if (req) begin
            case (i_wb_addr)
                uart_wb_pkg::ADDR_LEDS:    rdata_q <= {24'h0, leds_q};
                uart_wb_pkg::ADDR_SCRATCH: rdata_q <= scratch_q;
                uart_wb_pkg::ADDR_ID:      rdata_q <= uart_wb_pkg::ID_WORD;
                default:                   rdata_q <= '0;
            endcase
            if (i_wb_we && i_wb_addr == uart_wb_pkg::ADDR_SCRATCH) begin
                scratch_q <= i_wb_data;
            end
        end
    end

    a_ack_err_excl: assert property (@(posedge i_clk_12Mhz) disable iff (!i_rst_n)
        !(o_wb_ack && o_wb_err));

endmodule

// ==== rtl/wb_master.sv ====
`timescale 1ns/10ps

module wb_master (
    input  logic                  i_clk_12Mhz,
    input  logic                  i_rst_n,
    input  logic                  i_cmd_valid,
    input  uart_wb_pkg::cmd_t     i_cmd,
    output logic                  o_cmd_ready,
    output logic                  o_rsp_valid,
    output uart_wb_pkg::rsp_t     o_rsp,
    input  logic                  i_rsp_ready,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic                  o_wb_we,
    output uart_wb_pkg::wb_addr_t o_wb_addr,
    output uart_wb_pkg::word_t    o_wb_data,
    input  logic                  i_wb_stall,
    input  logic                  i_wb_ack,
    input  logic                  i_wb_err,
    input  uart_wb_pkg::word_t    i_wb_data
);

    typedef enum logic [1:0] {M_IDLE, M_REQ, M_WAIT, M_RESP} mst_state_t;

    mst_state_t            state;
    uart_wb_pkg::wb_addr_t addr_q;
    uart_wb_pkg::word_t    wdata_q;
    logic                  we_q;
    uart_wb_pkg::rsp_t     rsp_q;

    assign o_cmd_ready = (state == M_IDLE);
    assign o_rsp_valid = (state == M_RESP);
    assign o_rsp       = rsp_q;

    // cyc falls with the ack or err that ends the cycle
    assign o_wb_stb  = (state == M_REQ);
    assign o_wb_cyc  = o_wb_stb || (state == M_WAIT && !i_wb_ack && !i_wb_err);
    assign o_wb_we   = we_q;
    assign o_wb_addr = addr_q;
    assign o_wb_data = wdata_q;

    always_ff @(posedge i_clk_12Mhz) begin
        if (!i_rst_n) begin
            state  <= M_IDLE;
            addr_q <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (i_cmd_valid) begin
                        wdata_q <= i_cmd.data;
                        we_q    <= (i_cmd.op == uart_wb_pkg::OP_WRITE);
                        if (i_cmd.op == uart_wb_pkg::OP_SET_ADDR) begin
                            addr_q <= i_cmd.data[29:0];
                            rsp_q  <= '{code: uart_wb_pkg::RSP_ADDR_OK, data: '0};
                            state  <= M_RESP;
                        end else begin
                            state <= M_REQ;
                        end
                    end
                end
                M_REQ: begin
                    if (!i_wb_stall) begin
                        state <= M_WAIT;
                    end
                end
                M_WAIT: begin
                    if (i_wb_err) begin
                        rsp_q <= '{code: uart_wb_pkg::RSP_BUS_ERR, data: '0};
                        state <= M_RESP;
                    end else if (i_wb_ack) begin
                        rsp_q.code <= we_q ? uart_wb_pkg::RSP_WRITE_OK
                                           : uart_wb_pkg::RSP_READ_DATA;
                        rsp_q.data <= we_q ? '0 : i_wb_data;
                        state      <= M_RESP;
                    end
                end
                M_RESP: begin
                    if (i_rsp_ready) begin
                        state <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    a_stb_in_cyc: assert property (@(posedge i_clk_12Mhz) disable iff (!i_rst_n)
        o_wb_stb |-> o_wb_cyc);

    // One outstanding request at a time
    a_single_req: assert property (@(posedge i_clk_12Mhz) disable iff (!i_rst_n)
        o_wb_stb && !i_wb_stall |=> (!o_wb_stb until_with (i_wb_ack || i_wb_err)));

endmodule

// ==== uart_wb_bridge.f ====
rtl/uart_wb_pkg.sv
rtl/uart_rx.sv
rtl/cmd_decoder.sv
rtl/wb_master.sv
rtl/wb_led_slave.sv
rtl/rsp_encoder.sv
rtl/uart_tx.sv
rtl/uart_wb_bridge.sv
dv/tb_uart_wb_bridge.sv
